// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := tb_ceres_soc
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
+incdir+testbench
source/ceres_pkg.sv
source/ceres_bus_router.sv
source/ceres_main_ram.sv
source/ceres_clint.sv
source/ceres_gpio.sv
source/ceres_soc_fabric.sv
testbench/tb_ceres_soc.sv

// File: source/ceres_bus_router.sv
`timescale 1ns/10ps

module ceres_bus_router (
  input  ceres_pkg::bus_req_t           req_i,
  input  ceres_pkg::bus_res_t           ram_res_i,
  input  logic [ceres_pkg::DATA_W-1:0]  clint_rdata_i,
  input  logic [ceres_pkg::DATA_W-1:0]  gpio_rdata_i,
  output logic                          ram_sel_o,
  output logic                          clint_sel_o,
  output logic                          gpio_sel_o,
  output ceres_pkg::bus_res_t           res_o
);

  import ceres_pkg::*;

  // Region matches, before the valid qualifier
  logic ram_hit;
  logic clint_hit;
  logic periph_hit;
  // Any peripheral slot, mapped or not
  logic periph_sel;

  // ========================================
  // Region decode
  // ========================================

  // RAM owns the whole upper half
  assign ram_hit    = (req_i.addr.ram.region == MMAP_RAM_BASE[DATA_W-1]);
  // IO regions by top nibble
  assign clint_hit  = (req_i.addr.io.region == MMAP_CLINT_BASE[DATA_W-1:DATA_W-4]);
  assign periph_hit = (req_i.addr.io.region == MMAP_PERIPH_BASE[DATA_W-1:DATA_W-4]);

  always_comb begin
    ram_sel_o   = 1'b0;
    clint_sel_o = 1'b0;
    gpio_sel_o  = 1'b0;
    periph_sel  = 1'b0;

    if (req_i.valid) begin
      // RAM first, its region bit overlaps nothing else
      if (ram_hit) begin
        ram_sel_o = 1'b1;
      end else if (clint_hit) begin
        clint_sel_o = 1'b1;
      end else if (periph_hit) begin
        periph_sel = 1'b1;
        // Slot decode, only GPIO populated
        if (req_i.addr.io.slot == SLOT_GPIO) begin
          gpio_sel_o = 1'b1;
        end
      end
    end
  end

  // ========================================
  // Response select
  // ========================================

  always_comb begin
    // Unmapped regions stay silent
    res_o = '0;

    if (ram_sel_o) begin
      // RAM builds its own valid after the latency
      res_o = ram_res_i;
    end else if (clint_sel_o) begin
      // Same-cycle answer
      res_o.valid = 1'b1;
      res_o.rdata = clint_rdata_i;
    end else if (periph_sel) begin
      res_o.valid = 1'b1;
      // Empty slots read as zero
      if (gpio_sel_o) begin
        res_o.rdata = gpio_rdata_i;
      end
    end
  end

endmodule

// File: source/ceres_clint.sv
`timescale 1ns/10ps

module ceres_clint (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         sel_i,
  input  ceres_pkg::bus_req_t          req_i,
  output logic [ceres_pkg::DATA_W-1:0] rdata_o,
  output logic                         timer_irq_o,
  output logic                         sw_irq_o
);

  import ceres_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        msip_q;

  logic        we;
  // Slot and offset together form the 64 KB CLINT offset
  logic [15:0] off;

  assign off = {req_i.addr.io.slot, req_i.addr.io.offset};
  // Any strobe is a full-word write
  assign we  = sel_i & (|req_i.wstrb);

  // ========================================
  // Registers
  // ========================================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= MTIMECMP_RESET;
      msip_q     <= 1'b0;
    end else begin
      // Free-running time base
      mtime_q <= mtime_q + 64'd1;

      if (we) begin
        case (off)
          CLINT_MSIP_OFF:             msip_q                 <= req_i.wdata[0];
          CLINT_MTIMECMP_OFF:         mtimecmp_q[31:0]       <= req_i.wdata;
          CLINT_MTIMECMP_OFF + 16'd4: mtimecmp_q[63:32]      <= req_i.wdata;
          // Later assignment wins over the increment
          CLINT_MTIME_OFF:            mtime_q[31:0]          <= req_i.wdata;
          CLINT_MTIME_OFF + 16'd4:    mtime_q[63:32]         <= req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  // ========================================
  // Interrupts and readback
  // ========================================

  // Level, held until mtimecmp moves ahead
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

  always_comb begin
    case (off)
      CLINT_MSIP_OFF:             rdata_o = {{(DATA_W-1){1'b0}}, msip_q};
      CLINT_MTIMECMP_OFF:         rdata_o = mtimecmp_q[31:0];
      CLINT_MTIMECMP_OFF + 16'd4: rdata_o = mtimecmp_q[63:32];
      CLINT_MTIME_OFF:            rdata_o = mtime_q[31:0];
      CLINT_MTIME_OFF + 16'd4:    rdata_o = mtime_q[63:32];
      // Holes read zero
      default:                    rdata_o = '0;
    endcase
  end

endmodule

// File: source/ceres_gpio.sv
`timescale 1ns/10ps

module ceres_gpio (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         sel_i,
  input  ceres_pkg::bus_req_t          req_i,
  output logic [ceres_pkg::DATA_W-1:0] rdata_o,
  input  logic [ceres_pkg::GPIO_W-1:0] gpio_i,
  output logic [ceres_pkg::GPIO_W-1:0] gpio_o,
  output logic [ceres_pkg::GPIO_W-1:0] gpio_oe_o
);

  import ceres_pkg::*;

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  // Two-stage input synchronizer
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;

  logic              we;

  assign we = sel_i & (|req_i.wstrb);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q   <= '0;
      oe_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      // Pins are asynchronous to clk_i
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;

      if (we) begin
        case (req_i.addr.io.offset)
          GPIO_OUT_OFF: out_q <= req_i.wdata[GPIO_W-1:0];
          GPIO_OE_OFF:  oe_q  <= req_i.wdata[GPIO_W-1:0];
          // Input register is read-only
          default: ;
        endcase
      end
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;

  // Readback by offset
  always_comb begin
    case (req_i.addr.io.offset)
      GPIO_OUT_OFF: rdata_o = DATA_W'(out_q);
      GPIO_OE_OFF:  rdata_o = DATA_W'(oe_q);
      GPIO_IN_OFF:  rdata_o = DATA_W'(sync2_q);
      default:      rdata_o = '0;
    endcase
  end

endmodule

// File: source/ceres_main_ram.sv
`timescale 1ns/10ps

module ceres_main_ram (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                sel_i,
  input  ceres_pkg::bus_req_t req_i,
  output ceres_pkg::bus_res_t res_o
);

  import ceres_pkg::*;

  // Word storage
  logic [DATA_W-1:0]    mem_q [RAM_DEPTH];
  // Word seen at the accept edge
  logic [DATA_W-1:0]    rdata_q;

  // Set from accept until the requester lets go
  logic                 pending_q;
  // Edges since accept, stops at RAM_LATENCY + 1
  logic [RAM_CNT_W-1:0] cnt_q;

  logic                 accept;
  logic [RAM_IDX_W-1:0] idx;

  assign idx    = req_i.addr.ram.word_idx;
  // New request only when nothing is held
  assign accept = sel_i & ~pending_q;

  // ========================================
  // Latency control
  // ========================================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      cnt_q     <= '0;
    end else if (accept) begin
      pending_q <= 1'b1;
      cnt_q     <= '0;
    end else if (!sel_i) begin
      // Requester dropped valid, ready for the next one
      pending_q <= 1'b0;
      cnt_q     <= '0;
    end else if (pending_q && (cnt_q <= RAM_CNT_W'(RAM_LATENCY))) begin
      // Count past the response slot, then hold
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // ========================================
  // Storage
  // ========================================

  always_ff @(posedge clk_i) begin
    if (accept) begin
      // Old word out, read before write
      rdata_q <= mem_q[idx];
      // Per-lane write
      for (int b = 0; b < STRB_W; b++) begin
        if (req_i.wstrb[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Single-cycle pulse at RAM_LATENCY edges past accept
  assign res_o.valid = pending_q & (cnt_q == RAM_CNT_W'(RAM_LATENCY));
  assign res_o.rdata = rdata_q;

endmodule

// File: source/ceres_pkg.sv
package ceres_pkg;

  // ========================================
  // Bus geometry
  // ========================================

  // One 32-bit word per transfer
  localparam int DATA_W = 32;
  // One strobe per byte lane
  localparam int STRB_W = DATA_W / 8;

  // ========================================
  // Main RAM sizing
  // ========================================

  localparam int RAM_SIZE_KB = 4;
  localparam int RAM_DEPTH   = (RAM_SIZE_KB * 1024) / STRB_W;
  // Word index width, 10 bits for 1024 words
  localparam int RAM_IDX_W   = $clog2(RAM_DEPTH);
  // Edges from accept to response
  localparam int RAM_LATENCY = 4;
  // Counter must hold RAM_LATENCY + 1 once the response is done
  localparam int RAM_CNT_W   = $clog2(RAM_LATENCY + 2);

  // ========================================
  // Memory map
  // ========================================

  localparam logic [DATA_W-1:0] MMAP_RAM_BASE    = 32'h8000_0000;
  localparam logic [DATA_W-1:0] MMAP_CLINT_BASE  = 32'h3000_0000;
  localparam logic [DATA_W-1:0] MMAP_PERIPH_BASE = 32'h2000_0000;

  // 4 KB peripheral slots
  localparam logic [3:0] SLOT_GPIO = 4'd4;

  // CLINT offsets, high words at offset + 4
  localparam logic [15:0] CLINT_MSIP_OFF     = 16'h0000;
  localparam logic [15:0] CLINT_MTIMECMP_OFF = 16'h4000;
  localparam logic [15:0] CLINT_MTIME_OFF    = 16'hBFF8;

  // GPIO register offsets within the slot
  localparam logic [11:0] GPIO_OUT_OFF = 12'h000;
  localparam logic [11:0] GPIO_OE_OFF  = 12'h004;
  localparam logic [11:0] GPIO_IN_OFF  = 12'h008;

  localparam int GPIO_W = 32;

  // Timer disarmed out of reset
  localparam logic [63:0] MTIMECMP_RESET = 64'hFFFF_FFFF_FFFF_FFFF;

  // ========================================
  // Bus types
  // ========================================

  // Same address word, decoded per region
  typedef union packed {
    struct packed {
      logic                          region;
      logic [DATA_W-RAM_IDX_W-4:0]   rsvd;
      logic [RAM_IDX_W-1:0]          word_idx;
      logic [1:0]                    byte_off;
    } ram;
    struct packed {
      logic [3:0]  region;
      logic [11:0] rsvd;
      logic [3:0]  slot;
      logic [11:0] offset;
    } io;
  } bus_addr_u;

  // Zero strobes mean read
  typedef struct packed {
    logic              valid;
    bus_addr_u         addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } bus_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } bus_res_t;

endpackage

// File: source/ceres_soc_fabric.sv
`timescale 1ns/10ps

module ceres_soc_fabric (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  ceres_pkg::bus_req_t          req_i,
  output ceres_pkg::bus_res_t          res_o,
  input  logic [ceres_pkg::GPIO_W-1:0] gpio_i,
  output logic [ceres_pkg::GPIO_W-1:0] gpio_o,
  output logic [ceres_pkg::GPIO_W-1:0] gpio_oe_o,
  output logic                         timer_irq_o,
  output logic                         sw_irq_o
);

  import ceres_pkg::*;

  // Router selects
  logic              ram_sel;
  logic              clint_sel;
  logic              gpio_sel;

  // Target responses
  bus_res_t          ram_res;
  logic [DATA_W-1:0] clint_rdata;
  logic [DATA_W-1:0] gpio_rdata;

  // Decode and response select
  ceres_bus_router u_router (
    .req_i         (req_i),
    .ram_res_i     (ram_res),
    .clint_rdata_i (clint_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .ram_sel_o     (ram_sel),
    .clint_sel_o   (clint_sel),
    .gpio_sel_o    (gpio_sel),
    .res_o         (res_o)
  );

  // Main memory at 0x8000_0000
  ceres_main_ram u_main_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .sel_i  (ram_sel),
    .req_i  (req_i),
    .res_o  (ram_res)
  );

  // Timer and software interrupt source
  ceres_clint u_clint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sel_i       (clint_sel),
    .req_i       (req_i),
    .rdata_o     (clint_rdata),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

  // Peripheral slot 4
  ceres_gpio u_gpio (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .sel_i     (gpio_sel),
    .req_i     (req_i),
    .rdata_o   (gpio_rdata),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

endmodule

// File: testbench/tb_ceres_tasks.svh
`ifndef TB_CERES_TASKS_SVH
`define TB_CERES_TASKS_SVH

// Check and failure counters
int checks;
int value_errors;
int timeouts;

// Time at which the last request went out
time drive_time;

// Expected RAM contents by word index
logic [DATA_W-1:0] ram_model [RAM_DEPTH];

// Immediate check of one observed word
task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                           input logic [DATA_W-1:0] actual);
  checks++;
  assert (actual === expected) else begin
    value_errors++;
    $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
  end
endtask

// Request goes out just after the edge
task automatic drive_request(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [STRB_W-1:0] wstrb);
  @(posedge clk_i);
  #2;
  req.addr   = addr;
  req.wdata  = wdata;
  req.wstrb  = wstrb;
  req.valid  = 1'b1;
  drive_time = $time;
endtask

// Valid drops at the edge after the response
task automatic release_request();
  @(posedge clk_i);
  #2;
  req = '0;
endtask

// Full access, edges counts the rising edges before valid was seen
task automatic bus_access(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                          input logic [STRB_W-1:0] wstrb, output logic [DATA_W-1:0] rdata,
                          output int edges);
  bit done;
  edges = 0;
  done  = 1'b0;
  rdata = '0;
  drive_request(addr, wdata, wstrb);
  // Sample mid-cycle, away from both edges
  while (!done && edges < 20) begin
    @(negedge clk_i);
    if (res.valid) begin
      rdata = res.rdata;
      done  = 1'b1;
    end else begin
      @(posedge clk_i);
      edges++;
    end
  end
  if (!done) begin
    timeouts++;
    $display("Timeout: no response from address %h after %0d cycles", addr, edges);
  end
  release_request();
endtask

// Unmapped address, response must stay low the whole window
task automatic expect_silence(input logic [DATA_W-1:0] addr, input int cycles);
  drive_request(addr, '0, '0);
  for (int c = 0; c < cycles; c++) begin
    @(negedge clk_i);
    check_value("res_o.valid", 32'd0, 32'(res.valid));
    @(posedge clk_i);
  end
  #2;
  req = '0;
endtask

`endif

// File: testbench/tb_ceres_soc.sv
`timescale 1ns/10ps

module tb_ceres_soc;

  import ceres_pkg::*;

  logic              clk_i;
  logic              rst_ni;
  bus_req_t          req;
  bus_res_t          res;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic              timer_irq;
  logic              sw_irq;
  integer            seed;

  `include "tb_ceres_tasks.svh"

  ceres_soc_fabric dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req),
    .res_o       (res),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .timer_irq_o (timer_irq),
    .sw_irq_o    (sw_irq)
  );

  // 40 ns period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // RAM response lasts a single cycle even while the request is still held
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   dut0.ram_res.valid |=> !dut0.ram_res.valid)
    else begin
      value_errors++;
      $display("CHECK FAILED at %0t: RAM res_o.valid expected 0 actual 1", $time);
    end

  initial begin
    logic [RAM_IDX_W-1:0] idx_q [$];
    logic [DATA_W-1:0]    rd;
    logic [DATA_W-1:0]    wd;
    logic [DATA_W-1:0]    m;
    logic [DATA_W-1:0]    h;
    logic [DATA_W-1:0]    x;
    logic [DATA_W-1:0]    clint_base;
    logic [DATA_W-1:0]    gpio_base;
    logic [STRB_W-1:0]    strb;
    int                   lat;
    int                   n;
    time                  t0;

    seed       = 30;
    req        = '0;
    gpio_in    = '0;
    rst_ni     = 1'b0;
    clint_base = MMAP_CLINT_BASE;
    gpio_base  = MMAP_PERIPH_BASE + {16'h0, SLOT_GPIO, 12'h000};
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Reset state
    @(negedge clk_i);
    check_value("res_o.valid", 32'd0, 32'(res.valid));
    check_value("timer_irq_o", 32'd0, 32'(timer_irq));
    check_value("sw_irq_o", 32'd0, 32'(sw_irq));
    check_value("gpio_o", 32'd0, gpio_out);
    check_value("gpio_oe_o", 32'd0, gpio_oe);

    // ========================================
    // RAM strobes and latency
    // ========================================

    // Full-word seed then a random partial write on top
    for (int i = 0; i < 8; i++) begin
      idx_q.push_back(RAM_IDX_W'($random(seed)));
      wd = $random(seed);
      bus_access(MMAP_RAM_BASE + {20'h0, idx_q[i], 2'b00}, wd, 4'hF, rd, lat);
      check_value("RAM write latency", 32'(RAM_LATENCY), 32'(lat - 1));
      ram_model[idx_q[i]] = wd;
      wd   = $random(seed);
      strb = STRB_W'($random(seed));
      bus_access(MMAP_RAM_BASE + {20'h0, idx_q[i], 2'b00}, wd, strb, rd, lat);
      for (int b = 0; b < STRB_W; b++) begin
        if (strb[b]) begin
          ram_model[idx_q[i]][8*b +: 8] = wd[8*b +: 8];
        end
      end
    end
    foreach (idx_q[i]) begin
      bus_access(MMAP_RAM_BASE + {20'h0, idx_q[i], 2'b00}, '0, '0, rd, lat);
      check_value("res_o.rdata", ram_model[idx_q[i]], rd);
      check_value("RAM read latency", 32'(RAM_LATENCY), 32'(lat - 1));
    end

    // ========================================
    // mtime
    // ========================================

    bus_access(clint_base + {16'h0, CLINT_MTIME_OFF}, '0, '0, m, lat);
    check_value("CLINT latency", 32'd0, 32'(lat));
    t0 = drive_time;
    repeat (7) @(posedge clk_i);
    bus_access(clint_base + {16'h0, CLINT_MTIME_OFF}, '0, '0, rd, lat);
    n = int'((drive_time - t0) / 40);
    check_value("mtime low delta", 32'(n), rd - m);

    // Kept clear of a carry into the high word
    x = $random(seed) & 32'h0FFF_FFFF;
    bus_access(clint_base + {16'h0, CLINT_MTIME_OFF}, x, 4'hF, rd, lat);
    t0 = drive_time;
    repeat (3) @(posedge clk_i);
    bus_access(clint_base + {16'h0, CLINT_MTIME_OFF}, '0, '0, rd, lat);
    n = int'((drive_time - t0) / 40);
    check_value("mtime low", x + 32'(n) - 32'd1, rd);

    // ========================================
    // Timer and software interrupts
    // ========================================

    bus_access(clint_base + {16'h0, CLINT_MTIME_OFF} + 32'd4, '0, '0, h, lat);
    bus_access(clint_base + {16'h0, CLINT_MTIMECMP_OFF} + 32'd4, h, 4'hF, rd, lat);
    bus_access(clint_base + {16'h0, CLINT_MTIME_OFF}, '0, '0, m, lat);
    // Low half lands three edges after the read so 23 puts the target 20 ahead
    bus_access(clint_base + {16'h0, CLINT_MTIMECMP_OFF}, m + 32'd23, 4'hF, rd, lat);
    for (int i = 0; i < 15; i++) begin
      @(negedge clk_i);
      check_value("timer_irq_o", 32'd0, 32'(timer_irq));
    end
    n = 0;
    while (!timer_irq && n < 30) begin
      @(negedge clk_i);
      n++;
    end
    if (!timer_irq) begin
      timeouts++;
      $display("Timeout: timer interrupt did not rise within 30 cycles");
    end
    bus_access(clint_base + {16'h0, CLINT_MTIMECMP_OFF} + 32'd4, '1, 4'hF, rd, lat);
    @(negedge clk_i);
    check_value("timer_irq_o", 32'd0, 32'(timer_irq));

    bus_access(clint_base + {16'h0, CLINT_MSIP_OFF}, 32'd1, 4'hF, rd, lat);
    @(negedge clk_i);
    check_value("sw_irq_o", 32'd1, 32'(sw_irq));
    bus_access(clint_base + {16'h0, CLINT_MSIP_OFF}, '0, '0, rd, lat);
    check_value("msip", 32'd1, rd);
    bus_access(clint_base + {16'h0, CLINT_MSIP_OFF}, 32'd0, 4'hF, rd, lat);
    @(negedge clk_i);
    check_value("sw_irq_o", 32'd0, 32'(sw_irq));
    bus_access(clint_base + {16'h0, CLINT_MSIP_OFF}, '0, '0, rd, lat);
    check_value("msip", 32'd0, rd);

    // ========================================
    // GPIO and peripheral edges
    // ========================================

    wd = $random(seed);
    bus_access(gpio_base + {20'h0, GPIO_OUT_OFF}, wd, 4'hF, rd, lat);
    check_value("gpio_o", wd, gpio_out);
    bus_access(gpio_base + {20'h0, GPIO_OUT_OFF}, '0, '0, rd, lat);
    check_value("GPIO out readback", wd, rd);
    x = $random(seed);
    bus_access(gpio_base + {20'h0, GPIO_OE_OFF}, x, 4'hF, rd, lat);
    check_value("gpio_oe_o", x, gpio_oe);
    bus_access(gpio_base + {20'h0, GPIO_OE_OFF}, '0, '0, rd, lat);
    check_value("GPIO oe readback", x, rd);

    // Input held three edges before the read
    @(posedge clk_i);
    #2;
    gpio_in = $random(seed);
    repeat (3) @(posedge clk_i);
    bus_access(gpio_base + {20'h0, GPIO_IN_OFF}, '0, '0, rd, lat);
    check_value("GPIO input", gpio_in, rd);

    // Empty slot 7 answers zero at once
    bus_access(MMAP_PERIPH_BASE + 32'h0000_7000, '0, '0, rd, lat);
    check_value("slot 7 rdata", 32'd0, rd);
    check_value("slot 7 latency", 32'd0, 32'(lat));

    expect_silence(32'h1000_0000, 10);

    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
